// ==== dcore_pkg.sv ====
package dcore_pkg;

    // slice count and datapath widths
    localparam int Nti = 16;
    localparam int Nadc = 8;
    localparam int Ncode = 9;
    localparam int Nprbs = 7;
    localparam int Ncnt = 32;
    localparam int Naddr = 3;
    localparam int Ndata = 16;

    // limits of the signed code after offset removal
    localparam int CODE_MAX = 2 ** (Ncode - 1) - 1;
    localparam int CODE_MIN = -(2 ** (Ncode - 1));

    typedef logic [Nadc-1:0] adc_mag_t;
    typedef logic signed [Ncode-1:0] adc_code_t;
    typedef logic signed [Nadc-1:0] offset_t;
    // bit k belongs to slice k, slice 0 is the earliest
    typedef logic [Nti-1:0] rx_bits_t;
    typedef logic [Nprbs-1:0] prbs_state_t;
    typedef logic [Ncnt-1:0] count_t;
    typedef logic [Naddr-1:0] cfg_addr_t;
    typedef logic [Ndata-1:0] cfg_data_t;
    typedef logic [Ndata-1:0] test_len_t;

    // register map
    localparam cfg_addr_t ADDR_THRESH = 3'd0;
    localparam cfg_addr_t ADDR_OFFSET = 3'd1;
    localparam cfg_addr_t ADDR_PRBS_CTL = 3'd2;
    localparam cfg_addr_t ADDR_SEED = 3'd3;
    localparam cfg_addr_t ADDR_TEST_LEN = 3'd4;
    localparam cfg_addr_t ADDR_START = 3'd5;
    localparam cfg_addr_t ADDR_INJECT = 3'd6;

    // cycles spent loading the checker history before counting
    localparam int ALIGN_CYCLES = 2;

    typedef struct packed {
        adc_mag_t mag;
        logic sign;
    } adc_slice_t;

    typedef adc_slice_t [Nti-1:0] adc_word_t;
    typedef adc_code_t [Nti-1:0] code_word_t;

    typedef struct packed {
        logic we;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

    typedef struct packed {
        adc_code_t thresh;
        offset_t offset;
    } dp_cfg_t;

    typedef struct packed {
        logic enable;
        logic seed_load;
        prbs_state_t seed;
        logic inject;
    } bist_ctl_t;

    typedef struct packed {
        logic src_sel;
        logic align;
        logic check;
    } chk_ctl_t;

    typedef struct packed {
        count_t err_count;
        count_t bit_count;
        logic done;
    } prbs_result_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ALIGN,
        SEQ_CHECK,
        SEQ_DONE
    } seq_state_t;

endpackage

// ==== dcore_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcore_ctrl (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::cfg_wr_t cfg_i,
    input wire dcore_pkg::prbs_result_t result_i,
    output dcore_pkg::dp_cfg_t dp_cfg_o,
    output dcore_pkg::bist_ctl_t bist_ctl_o,
    output dcore_pkg::chk_ctl_t chk_ctl_o,
    output dcore_pkg::prbs_result_t result_o,
    output logic busy_o
);
    dcore_pkg::adc_code_t thresh_r;
    dcore_pkg::offset_t offset_r;
    logic src_sel_r;
    logic bist_en_r;
    dcore_pkg::prbs_state_t seed_r;
    dcore_pkg::test_len_t test_len_r;
    logic seed_load_r;
    logic start_r;
    logic inject_r;
    dcore_pkg::seq_state_t state_r;
    dcore_pkg::test_len_t phase_cnt_r;

    // register file, written on every edge with we high
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            thresh_r <= '0;
            offset_r <= '0;
            src_sel_r <= 1'b0;
            bist_en_r <= 1'b0;
            seed_r <= '0;
            test_len_r <= '0;
            seed_load_r <= 1'b0;
            start_r <= 1'b0;
            inject_r <= 1'b0;
        end else begin
            // strobes last exactly one cycle
            seed_load_r <= cfg_i.we && (cfg_i.addr == dcore_pkg::ADDR_SEED);
            start_r <= cfg_i.we && (cfg_i.addr == dcore_pkg::ADDR_START);
            inject_r <= cfg_i.we && (cfg_i.addr == dcore_pkg::ADDR_INJECT);
            if (cfg_i.we) begin
                case (cfg_i.addr)
                    dcore_pkg::ADDR_THRESH: thresh_r <= cfg_i.data[dcore_pkg::Ncode-1:0];
                    dcore_pkg::ADDR_OFFSET: offset_r <= cfg_i.data[dcore_pkg::Nadc-1:0];
                    dcore_pkg::ADDR_PRBS_CTL: begin
                        src_sel_r <= cfg_i.data[0];
                        bist_en_r <= cfg_i.data[1];
                    end
                    dcore_pkg::ADDR_SEED: seed_r <= cfg_i.data[dcore_pkg::Nprbs-1:0];
                    dcore_pkg::ADDR_TEST_LEN: test_len_r <= cfg_i.data;
                    default: ;
                endcase
            end
        end
    end

    // test sequencer, one down-counter shared by align and check
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state_r <= dcore_pkg::SEQ_IDLE;
            phase_cnt_r <= '0;
        end else begin
            case (state_r)
                dcore_pkg::SEQ_IDLE, dcore_pkg::SEQ_DONE: begin
                    if (start_r) begin
                        state_r <= dcore_pkg::SEQ_ALIGN;
                        phase_cnt_r <= dcore_pkg::test_len_t'(dcore_pkg::ALIGN_CYCLES - 1);
                    end
                end
                dcore_pkg::SEQ_ALIGN: begin
                    if (phase_cnt_r == '0) begin
                        // zero length means nothing to check
                        if (test_len_r == '0) begin
                            state_r <= dcore_pkg::SEQ_DONE;
                        end else begin
                            state_r <= dcore_pkg::SEQ_CHECK;
                            phase_cnt_r <= test_len_r - 1'b1;
                        end
                    end else begin
                        phase_cnt_r <= phase_cnt_r - 1'b1;
                    end
                end
                default: begin
                    if (phase_cnt_r == '0) begin
                        state_r <= dcore_pkg::SEQ_DONE;
                    end else begin
                        phase_cnt_r <= phase_cnt_r - 1'b1;
                    end
                end
            endcase
        end
    end

    assign dp_cfg_o = '{thresh: thresh_r, offset: offset_r};
    assign bist_ctl_o = '{enable: bist_en_r, seed_load: seed_load_r, seed: seed_r,
                          inject: inject_r};
    assign chk_ctl_o = '{src_sel: src_sel_r,
                         align: (state_r == dcore_pkg::SEQ_ALIGN),
                         check: (state_r == dcore_pkg::SEQ_CHECK)};

    // counts come from the checker, done from the sequencer
    assign result_o = '{err_count: result_i.err_count, bit_count: result_i.bit_count,
                        done: (state_r == dcore_pkg::SEQ_DONE)};
    assign busy_o = (state_r == dcore_pkg::SEQ_ALIGN) || (state_r == dcore_pkg::SEQ_CHECK);

endmodule

`default_nettype wire

// ==== adc_unfolding.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_unfolding (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::adc_word_t adc_i,
    input wire dcore_pkg::offset_t offset_i,
    output dcore_pkg::code_word_t codes_o
);

    // signed code from one slice, offset removed and clipped to the code range
    function automatic dcore_pkg::adc_code_t unfold(input dcore_pkg::adc_slice_t slice,
                                                    input dcore_pkg::offset_t offset);
        logic signed [dcore_pkg::Ncode:0] mag_s;
        logic signed [dcore_pkg::Ncode:0] diff;
        mag_s = $signed({2'b00, slice.mag});
        // sign 1 is the positive half
        diff = (slice.sign ? mag_s : -mag_s) - offset;
        if (diff > dcore_pkg::CODE_MAX) begin
            unfold = dcore_pkg::adc_code_t'(dcore_pkg::CODE_MAX);
        end else if (diff < dcore_pkg::CODE_MIN) begin
            unfold = dcore_pkg::adc_code_t'(dcore_pkg::CODE_MIN);
        end else begin
            unfold = diff[dcore_pkg::Ncode-1:0];
        end
    endfunction

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            codes_o <= '0;
        end else begin
            for (int k = 0; k < dcore_pkg::Nti; k++) begin
                codes_o[k] <= unfold(adc_i[k], offset_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== digital_comparator.sv ====
`timescale 1ns/10ps
`default_nettype none

module digital_comparator (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::code_word_t codes_i,
    input wire dcore_pkg::adc_code_t thresh_i,
    output dcore_pkg::rx_bits_t bits_o
);
    dcore_pkg::rx_bits_t above;

    // strict compare, a code equal to the threshold slices to 0
    always_comb begin
        for (int k = 0; k < dcore_pkg::Nti; k++) begin
            above[k] = $signed(codes_i[k]) > thresh_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= above;
        end
    end

endmodule

`default_nettype wire

// ==== prbs_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module prbs_generator (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::bist_ctl_t ctl_i,
    output dcore_pkg::rx_bits_t bits_o
);
    // state[0] is the oldest of the last seven bits
    dcore_pkg::prbs_state_t state_r;
    dcore_pkg::prbs_state_t state_next;
    dcore_pkg::rx_bits_t word;

    // unroll x^7+x^6+1 over one word, slice 0 first
    always_comb begin
        state_next = state_r;
        for (int k = 0; k < dcore_pkg::Nti; k++) begin
            word[k] = state_next[0] ^ state_next[1];
            state_next = {word[k], state_next[dcore_pkg::Nprbs-1:1]};
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state_r <= '0;
            bits_o <= '0;
        end else if (ctl_i.seed_load) begin
            state_r <= ctl_i.seed;
        end else if (ctl_i.enable) begin
            state_r <= state_next;
            // injected error only touches the output, the sequence runs on
            bits_o <= word ^ dcore_pkg::rx_bits_t'(ctl_i.inject);
        end
    end

endmodule

`default_nettype wire

// ==== prbs_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module prbs_checker (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::chk_ctl_t ctl_i,
    input wire dcore_pkg::rx_bits_t adc_bits_i,
    input wire dcore_pkg::rx_bits_t bist_bits_i,
    output dcore_pkg::prbs_result_t result_o
);
    dcore_pkg::rx_bits_t rx_bits;
    // last seven bits of the previous word, index 0 oldest
    dcore_pkg::prbs_state_t hist_r;
    logic [dcore_pkg::Nti+dcore_pkg::Nprbs-1:0] ext_bits;
    dcore_pkg::rx_bits_t err_vec;
    dcore_pkg::count_t err_sum;
    dcore_pkg::count_t err_cnt_r;
    dcore_pkg::count_t bit_cnt_r;

    assign rx_bits = ctl_i.src_sel ? bist_bits_i : adc_bits_i;
    assign ext_bits = {rx_bits, hist_r};

    // each bit is predicted from the bits seven and six before it
    always_comb begin
        err_sum = '0;
        for (int k = 0; k < dcore_pkg::Nti; k++) begin
            err_vec[k] = rx_bits[k] ^ ext_bits[k] ^ ext_bits[k+1];
            err_sum = err_sum + dcore_pkg::count_t'(err_vec[k]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist_r <= '0;
        end else begin
            // history follows the data in every state
            hist_r <= rx_bits[dcore_pkg::Nti-1:dcore_pkg::Nti-dcore_pkg::Nprbs];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            err_cnt_r <= '0;
            bit_cnt_r <= '0;
        end else if (ctl_i.align) begin
            err_cnt_r <= '0;
            bit_cnt_r <= '0;
        end else if (ctl_i.check) begin
            err_cnt_r <= err_cnt_r + err_sum;
            bit_cnt_r <= bit_cnt_r + dcore_pkg::count_t'(dcore_pkg::Nti);
        end
    end

    // done belongs to the sequencer
    assign result_o = '{err_count: err_cnt_r, bit_count: bit_cnt_r, done: 1'b0};

endmodule

`default_nettype wire

// ==== rx_digital_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_digital_core (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire dcore_pkg::adc_word_t adc_i,
    input wire dcore_pkg::cfg_wr_t cfg_i,
    output wire dcore_pkg::code_word_t codes_o,
    output wire dcore_pkg::rx_bits_t rx_bits_o,
    output wire dcore_pkg::prbs_result_t result_o,
    output wire logic busy_o
);
    // control to datapath
    wire dcore_pkg::dp_cfg_t dp_cfg;
    wire dcore_pkg::bist_ctl_t bist_ctl;
    wire dcore_pkg::chk_ctl_t chk_ctl;
    wire dcore_pkg::prbs_result_t chk_result;
    wire dcore_pkg::rx_bits_t bist_bits;

    dcore_ctrl ctrl_i (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .cfg_i(cfg_i),
        .result_i(chk_result),
        .dp_cfg_o(dp_cfg),
        .bist_ctl_o(bist_ctl),
        .chk_ctl_o(chk_ctl),
        .result_o(result_o),
        .busy_o(busy_o)
    );

    adc_unfolding unfold_i (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .adc_i(adc_i),
        .offset_i(dp_cfg.offset),
        .codes_o(codes_o)
    );

    // slicer feeds both the output and the checker
    digital_comparator dig_comp_i (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .codes_i(codes_o),
        .thresh_i(dp_cfg.thresh),
        .bits_o(rx_bits_o)
    );

    prbs_generator prbs_gen_i (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .ctl_i(bist_ctl),
        .bits_o(bist_bits)
    );

    prbs_checker prbs_chk_i (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .ctl_i(chk_ctl),
        .adc_bits_i(rx_bits_o),
        .bist_bits_i(bist_bits),
        .result_o(chk_result)
    );

endmodule

`default_nettype wire

// ==== rx_digital_core_properties.sv ====
`timescale 1ns/10ps

module rx_digital_core_properties (
    input logic clk_adc,
    input logic rst_i,
    input dcore_pkg::prbs_result_t result_i,
    input logic busy_i
);

    // a test is either running or finished
    busy_done_excl: assert property (@(posedge clk_adc) disable iff (rst_i)
        !(busy_i && result_i.done))
        else $error("busy and done high in the same cycle");

    errors_within_bits: assert property (@(posedge clk_adc) disable iff (rst_i)
        result_i.err_count <= result_i.bit_count)
        else $error("error count above bit count");

    // counts frozen once the sequencer reports done
    counts_held_done: assert property (@(posedge clk_adc) disable iff (rst_i)
        result_i.done |=> (!result_i.done ||
                           ($stable(result_i.err_count) && $stable(result_i.bit_count))))
        else $error("counts changed while done was high");

    idle_after_reset: assert property (@(posedge clk_adc) rst_i |=> !busy_i)
        else $error("busy high in the cycle after reset");

endmodule

bind rx_digital_core rx_digital_core_properties props0 (
    .clk_adc(clk_adc),
    .rst_i(rst_i),
    .result_i(result_o),
    .busy_i(busy_o)
);

// ==== tb_rx_digital_core.sv ====
`timescale 1ns/10ps

module tb_rx_digital_core;

    localparam int WAIT_LIMIT = 200;

    logic clk_adc;
    logic rst_i;
    dcore_pkg::adc_word_t adc_i;
    dcore_pkg::cfg_wr_t cfg_i;
    dcore_pkg::code_word_t codes_o;
    dcore_pkg::rx_bits_t rx_bits_o;
    dcore_pkg::prbs_result_t result_o;
    logic busy_o;

    // reference model registers, updated once per clock edge
    dcore_pkg::code_word_t codes_m;
    dcore_pkg::rx_bits_t bits_m;
    dcore_pkg::offset_t offset_m;
    dcore_pkg::adc_code_t thresh_m;
    dcore_pkg::test_len_t len_m;
    dcore_pkg::test_len_t run_len;
    dcore_pkg::prbs_state_t hist_m;
    dcore_pkg::count_t err_m;
    int cyc;
    int start_cyc;

    // sign source for the ADC run, index 0 oldest
    logic sign_prbs;
    dcore_pkg::prbs_state_t sw_hist;
    int flip_pct;

    rx_digital_core dut0 (
        .clk_adc(clk_adc),
        .rst_i(rst_i),
        .adc_i(adc_i),
        .cfg_i(cfg_i),
        .codes_o(codes_o),
        .rx_bits_o(rx_bits_o),
        .result_o(result_o),
        .busy_o(busy_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #50 clk_adc = ~clk_adc;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_codes(input dcore_pkg::code_word_t exp, input dcore_pkg::code_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch codes_o: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_bits(input dcore_pkg::rx_bits_t exp, input dcore_pkg::rx_bits_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch rx_bits_o: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_result(input dcore_pkg::prbs_result_t exp,
                                input dcore_pkg::prbs_result_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch result_o: expected %h, got %h", exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
        end
    endtask

    // sign selects the half, then offset removal and clipping to 9 bits
    function automatic dcore_pkg::adc_code_t unfold_ref(input dcore_pkg::adc_slice_t s,
                                                        input dcore_pkg::offset_t off);
        int v;
        v = s.sign ? int'(s.mag) : -int'(s.mag);
        v = v - int'(off);
        if (v > dcore_pkg::CODE_MAX) v = dcore_pkg::CODE_MAX;
        if (v < dcore_pkg::CODE_MIN) v = dcore_pkg::CODE_MIN;
        return dcore_pkg::adc_code_t'(v);
    endfunction

    // b[n] should equal b[n-7] xor b[n-6]
    function automatic dcore_pkg::count_t count_mispredicted(input dcore_pkg::rx_bits_t w,
                                                             input dcore_pkg::prbs_state_t hist);
        logic [dcore_pkg::Nti+dcore_pkg::Nprbs-1:0] seq;
        dcore_pkg::count_t n;
        seq = {w, hist};
        n = '0;
        for (int i = dcore_pkg::Nprbs; i < dcore_pkg::Nti + dcore_pkg::Nprbs; i++) begin
            if (seq[i] != (seq[i-7] ^ seq[i-6])) n++;
        end
        return n;
    endfunction

    function automatic dcore_pkg::adc_word_t next_adc();
        dcore_pkg::adc_word_t w;
        logic b;
        for (int k = 0; k < dcore_pkg::Nti; k++) begin
            if (sign_prbs) begin
                b = sw_hist[0] ^ sw_hist[1];
                sw_hist = {b, sw_hist[dcore_pkg::Nprbs-1:1]};
                w[k].mag = dcore_pkg::adc_mag_t'($urandom_range(255, 1));
                w[k].sign = b ^ ($urandom_range(99) < flip_pct);
            end else begin
                // extremes in half the slices
                case ($urandom_range(3))
                    0: w[k].mag = '0;
                    1: w[k].mag = '1;
                    default: w[k].mag = dcore_pkg::adc_mag_t'($urandom_range(255));
                endcase
                w[k].sign = $urandom_range(1);
            end
        end
        return w;
    endfunction

    // one clock: drive at the falling edge, model the rising edge, compare
    task automatic step(input dcore_pkg::cfg_wr_t c);
        dcore_pkg::adc_word_t a;
        int k;
        a = next_adc();
        adc_i = a;
        cfg_i = c;
        @(posedge clk_adc);
        @(negedge clk_adc);
        cyc++;
        k = cyc - start_cyc;
        // checker consumes the word sliced at the previous edge
        if (start_cyc >= 0 && k >= 4 && k <= 3 + int'(run_len)) begin
            err_m = err_m + count_mispredicted(bits_m, hist_m);
        end
        hist_m = bits_m[dcore_pkg::Nti-1:dcore_pkg::Nti-dcore_pkg::Nprbs];
        for (int i = 0; i < dcore_pkg::Nti; i++) begin
            bits_m[i] = ($signed(codes_m[i]) > $signed(thresh_m));
            codes_m[i] = unfold_ref(a[i], offset_m);
        end
        if (c.we) begin
            case (c.addr)
                dcore_pkg::ADDR_THRESH: thresh_m = c.data[dcore_pkg::Ncode-1:0];
                dcore_pkg::ADDR_OFFSET: offset_m = c.data[dcore_pkg::Nadc-1:0];
                dcore_pkg::ADDR_TEST_LEN: len_m = c.data;
                dcore_pkg::ADDR_START: begin
                    start_cyc = cyc;
                    run_len = len_m;
                    err_m = '0;
                end
                default: ;
            endcase
        end
        k = cyc - start_cyc;
        check_codes(codes_m, codes_o);
        check_bits(bits_m, rx_bits_o);
        check_flag("busy_o", start_cyc >= 0 && k >= 1 && k <= 2 + int'(run_len), busy_o);
    endtask

    task automatic write_reg(input dcore_pkg::cfg_addr_t addr, input int data);
        dcore_pkg::cfg_wr_t wr;
        wr.we = 1'b1;
        wr.addr = addr;
        wr.data = dcore_pkg::cfg_data_t'(data);
        step(wr);
    endtask

    task automatic wait_test_end();
        int n;
        n = 0;
        while (busy_o !== 1'b1) begin
            if (n == WAIT_LIMIT) stop_on_error("timeout: busy_o never rose after the start write");
            step('0);
            n++;
        end
        n = 0;
        while (result_o.done !== 1'b1) begin
            if (n == WAIT_LIMIT) stop_on_error("timeout: result_o.done never rose during a test");
            step('0);
            n++;
        end
    endtask

    initial begin
        dcore_pkg::prbs_result_t exp_res;
        int len;
        void'($urandom(9030));
        rst_i = 1'b1;
        adc_i = '0;
        cfg_i = '0;
        codes_m = '0;
        bits_m = '0;
        offset_m = '0;
        thresh_m = '0;
        len_m = '0;
        run_len = '0;
        hist_m = '0;
        err_m = '0;
        cyc = 0;
        start_cyc = -1;
        sign_prbs = 1'b0;
        sw_hist = 7'h01;
        flip_pct = 0;
        repeat (2) @(posedge clk_adc);
        @(negedge clk_adc);
        rst_i = 1'b0;
        check_codes('0, codes_o);
        check_bits('0, rx_bits_o);
        check_result('0, result_o);
        check_flag("busy_o", 1'b0, busy_o);

        // unfolding and slicing under changing offset and threshold
        repeat (4) begin
            write_reg(dcore_pkg::ADDR_OFFSET, $urandom_range(255));
            write_reg(dcore_pkg::ADDR_THRESH, $urandom_range(511));
            repeat (10) step('0);
        end

        // BIST runs, the second with one injected error
        write_reg(dcore_pkg::ADDR_PRBS_CTL, 3);
        for (int run = 0; run < 2; run++) begin
            len = (run == 0) ? $urandom_range(60, 20) : $urandom_range(60, 40);
            write_reg(dcore_pkg::ADDR_TEST_LEN, len);
            write_reg(dcore_pkg::ADDR_SEED, $urandom_range(127, 1));
            repeat (3) step('0);
            write_reg(dcore_pkg::ADDR_START, 0);
            if (run == 1) begin
                repeat ($urandom_range(19, 9)) step('0);
                write_reg(dcore_pkg::ADDR_INJECT, 0);
            end
            wait_test_end();
            // flipped bit plus the two predictions that read it
            exp_res.err_count = (run == 1) ? 32'd3 : 32'd0;
            exp_res.bit_count = dcore_pkg::count_t'(16 * len);
            exp_res.done = 1'b1;
            check_result(exp_res, result_o);
        end

        // ADC source with PRBS signs and a few flipped slices
        write_reg(dcore_pkg::ADDR_PRBS_CTL, 0);
        write_reg(dcore_pkg::ADDR_THRESH, 0);
        write_reg(dcore_pkg::ADDR_OFFSET, 0);
        sw_hist = dcore_pkg::prbs_state_t'($urandom_range(127, 1));
        flip_pct = $urandom_range(3, 1);
        sign_prbs = 1'b1;
        len = $urandom_range(60, 20);
        write_reg(dcore_pkg::ADDR_TEST_LEN, len);
        repeat (4) step('0);
        write_reg(dcore_pkg::ADDR_START, 0);
        wait_test_end();
        exp_res.err_count = err_m;
        exp_res.bit_count = dcore_pkg::count_t'(16 * len);
        exp_res.done = 1'b1;
        check_result(exp_res, result_o);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
dcore_pkg.sv
dcore_ctrl.sv
adc_unfolding.sv
digital_comparator.sv
prbs_generator.sv
prbs_checker.sv
rx_digital_core.sv
rx_digital_core_properties.sv
tb_rx_digital_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_rx_digital_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass line missing from $LOG"
exit 1
